// File: include/tone_synth_consts.svh
/*
 * tone_synth constants
 * widths, channel count, register map and sample divider
 */
`ifndef TONE_SYNTH_CONSTS_SVH
`define TONE_SYNTH_CONSTS_SVH

// widths and counts
`define TS_DATA_W   8      // host bus and register byte
`define TS_NUM_CH   4      // voice channels
`define TS_FNUM_W   10     // frequency number
`define TS_BLOCK_W  3      // octave block
`define TS_ATTEN_W  3      // arithmetic shift amount
`define TS_PHASE_W  20     // phase accumulator
`define TS_VOICE_W  16     // signed per-channel sample
`define TS_MIX_W    18     // signed stereo sum
`define TS_CLK_DIV  16     // clocks per sample period

// register indices
`define TS_REG_T1         8'h02   // timer 1 reload
`define TS_REG_T2         8'h03   // timer 2 reload
`define TS_REG_TCTL       8'h04   // start, mask, flag reset
`define TS_REG_FNUM_BASE  8'hA0   // fnum low byte, ch 0..3
`define TS_REG_KEY_BASE   8'hB0   // kon, block, fnum high bits
`define TS_REG_VOICE_BASE 8'hC0   // pan, wave, atten

`endif

// File: source/tone_synth_pkg.sv
/*
 * tone_synth package
 * register group and waveform types shared by the design
 */
`default_nettype none

package tone_synth_pkg;

    // register group, as decoded from the latched index
    typedef enum logic [2:0] {
        REG_NONE,     // unmapped, write dropped
        REG_T1,
        REG_T2,
        REG_TCTL,
        REG_FNUM,     // per channel
        REG_KEY,      // per channel
        REG_VOICE     // per channel
    } reg_group_e;

    // channel waveform select
    typedef enum logic {
        WAVE_SAW,     // top phase bits
        WAVE_SQUARE   // phase msb only
    } wave_e;

endpackage

`default_nettype wire

// File: source/voice_regs_if.sv
/*
 * voice_regs_if
 * per-channel voice settings, register file to engine and mixer
 */
`timescale 1ns/1ns
`default_nettype none
`include "tone_synth_consts.svh"

interface voice_regs_if;
    import tone_synth_pkg::*;

    logic [`TS_FNUM_W-1:0]  fnum  [`TS_NUM_CH];
    logic [`TS_BLOCK_W-1:0] block [`TS_NUM_CH];  // octave shift of fnum
    logic [`TS_ATTEN_W-1:0] atten [`TS_NUM_CH];  // right shift of sample
    wave_e                  wave  [`TS_NUM_CH];
    logic [`TS_NUM_CH-1:0]  kon;                 // one bit per channel
    logic [`TS_NUM_CH-1:0]  pan_l;
    logic [`TS_NUM_CH-1:0]  pan_r;

    modport regs   (output fnum, block, atten, wave, kon, pan_l, pan_r);
    modport engine (input fnum, block, atten, wave, kon);
    modport mixer  (input kon, pan_l, pan_r);

endinterface

`default_nettype wire

// File: source/host_port.sv
/*
 * host_port
 * chip-select bus decode, index latch, write strobe and status readback
 */
`timescale 1ns/1ns
`default_nettype none
`include "tone_synth_consts.svh"

module host_port (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   cs_n,
    input  wire                   rd_n,
    input  wire                   wr_n,
    input  wire [1:0]             address,
    input  wire [`TS_DATA_W-1:0]  din,
    input  wire [`TS_DATA_W-1:0]  status,
    output logic [`TS_DATA_W-1:0] dout,
    output logic                  reg_wr,
    output logic [`TS_DATA_W-1:0] reg_index,
    output logic [`TS_DATA_W-1:0] reg_data
);
    logic wr_en;
    logic rd_en;

    assign wr_en = !cs_n && !wr_n;
    assign rd_en = !cs_n && !rd_n;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_index <= '0;
            reg_data  <= '0;
            reg_wr    <= 1'b0;
        end else begin
            reg_wr <= wr_en && (address == 2'd1);   // one-cycle data strobe
            if (wr_en && address == 2'd0)
                reg_index <= din;                  // index latch
            if (wr_en && address == 2'd1)
                reg_data <= din;                   // lines up with reg_wr
        end
    end

    // status byte only, level read
    assign dout = (rd_en && address == 2'd0) ? status : '0;

    a_no_rd_wr: assert property (@(posedge clk) disable iff (!arst_n)
        !cs_n |-> (rd_n || wr_n));

endmodule

`default_nettype wire

// File: source/register_file.sv
/*
 * register_file
 * decodes host writes into voice settings, timer reloads and timer control
 */
`timescale 1ns/1ns
`default_nettype none
`include "tone_synth_consts.svh"

module register_file (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   reg_wr,
    input  wire [`TS_DATA_W-1:0]  reg_index,
    input  wire [`TS_DATA_W-1:0]  reg_data,
    voice_regs_if.regs            regs,
    output logic [`TS_DATA_W-1:0] t1_reload,
    output logic [`TS_DATA_W-1:0] t2_reload,
    output logic                  t1_start,
    output logic                  t2_start,
    output logic                  t1_mask,
    output logic                  t2_mask,
    output logic                  flag_clr
);
    import tone_synth_pkg::*;

    localparam int CH_W = $clog2(`TS_NUM_CH);

    reg_group_e            grp;
    logic [CH_W-1:0]       ch;
    logic [`TS_DATA_W-1:0] idx_base;

    assign ch       = reg_index[CH_W-1:0];
    assign idx_base = reg_index & ~(`TS_DATA_W'(`TS_NUM_CH - 1));  // strip channel bits

    always_comb begin
        grp = REG_NONE;
        if (reg_index == `TS_REG_T1)
            grp = REG_T1;
        else if (reg_index == `TS_REG_T2)
            grp = REG_T2;
        else if (reg_index == `TS_REG_TCTL)
            grp = REG_TCTL;
        else if (idx_base == `TS_REG_FNUM_BASE)
            grp = REG_FNUM;
        else if (idx_base == `TS_REG_KEY_BASE)
            grp = REG_KEY;
        else if (idx_base == `TS_REG_VOICE_BASE)
            grp = REG_VOICE;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            t1_reload   <= '0;
            t2_reload   <= '0;
            t1_start    <= 1'b0;
            t2_start    <= 1'b0;
            t1_mask     <= 1'b0;
            t2_mask     <= 1'b0;
            flag_clr    <= 1'b0;
            regs.kon    <= '0;
            regs.pan_l  <= '0;
            regs.pan_r  <= '0;
            for (int i = 0; i < `TS_NUM_CH; i++) begin
                regs.fnum[i]  <= '0;
                regs.block[i] <= '0;
                regs.atten[i] <= '0;
                regs.wave[i]  <= WAVE_SAW;
            end
        end else begin
            flag_clr <= reg_wr && grp == REG_TCTL && reg_data[7];  // not stored
            if (reg_wr) begin
                case (grp)
                    REG_T1:   t1_reload <= reg_data;
                    REG_T2:   t2_reload <= reg_data;
                    REG_TCTL: begin
                        t1_start <= reg_data[0];
                        t2_start <= reg_data[1];
                        t2_mask  <= reg_data[5];
                        t1_mask  <= reg_data[6];
                    end
                    REG_FNUM: regs.fnum[ch][7:0] <= reg_data;
                    REG_KEY: begin
                        regs.kon[ch]       <= reg_data[5];
                        regs.block[ch]     <= reg_data[4:2];
                        regs.fnum[ch][9:8] <= reg_data[1:0];  // high fnum bits
                    end
                    REG_VOICE: begin
                        regs.pan_r[ch] <= reg_data[5];
                        regs.pan_l[ch] <= reg_data[4];
                        regs.wave[ch]  <= wave_e'(reg_data[3]);
                        regs.atten[ch] <= reg_data[2:0];
                    end
                    default: ;                                 // unmapped index
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: source/timers.sv
/*
 * timers
 * two reloadable 8-bit interval timers with overflow flags and irq_n
 */
`timescale 1ns/1ns
`default_nettype none
`include "tone_synth_consts.svh"

module timers (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   tick,
    input  wire [`TS_DATA_W-1:0]  t1_reload,
    input  wire [`TS_DATA_W-1:0]  t2_reload,
    input  wire                   t1_start,
    input  wire                   t2_start,
    input  wire                   t1_mask,
    input  wire                   t2_mask,
    input  wire                   flag_clr,
    output logic [`TS_DATA_W-1:0] status,
    output logic                  irq_n
);
    logic [1:0]            t2_pre;        // divide-by-4 for timer 2
    logic [1:0]            start;         // index 0 is timer 1
    logic [1:0]            adv;
    logic [1:0]            flag;
    logic [`TS_DATA_W-1:0] reload [2];
    logic [`TS_DATA_W-1:0] cnt    [2];
    logic                  irq;

    assign start     = {t2_start, t1_start};
    assign reload[0] = t1_reload;
    assign reload[1] = t2_reload;
    assign adv       = {tick && t2_pre == 2'd3, tick};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            t2_pre <= '0;
        else if (!t2_start)
            t2_pre <= '0;                 // restart prescale with timer
        else if (tick)
            t2_pre <= t2_pre + 2'd1;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flag <= '0;
            for (int i = 0; i < 2; i++)
                cnt[i] <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (!start[i])
                    cnt[i] <= reload[i];  // parked at reload
                else if (adv[i])
                    cnt[i] <= (cnt[i] == '1) ? reload[i] : cnt[i] + 1'b1;
                if (flag_clr)
                    flag[i] <= 1'b0;
                else if (start[i] && adv[i] && cnt[i] == '1)
                    flag[i] <= 1'b1;      // set even when masked
            end
        end
    end

    assign irq = (flag[0] && !t1_mask) || (flag[1] && !t2_mask);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            irq_n <= 1'b1;
        else
            irq_n <= !irq;
    end

    assign status = {irq, flag[0], flag[1], {(`TS_DATA_W-3){1'b0}}};

    a_irq_idle: assert property (@(posedge clk) disable iff (!arst_n)
        (flag == 2'b00) |=> irq_n);

endmodule

`default_nettype wire

// File: source/voice_engine.sv
/*
 * voice_engine
 * sample tick divider, four phase accumulators and saw/square shaping
 */
`timescale 1ns/1ns
`default_nettype none
`include "tone_synth_consts.svh"

module voice_engine #(
    parameter int CLK_DIV = `TS_CLK_DIV
) (
    input  wire                          clk,
    input  wire                          arst_n,
    voice_regs_if.engine                 regs,
    output logic                         tick,
    output logic signed [`TS_VOICE_W-1:0] voice_out [`TS_NUM_CH]
);
    import tone_synth_pkg::*;

    localparam int DIV_W = $clog2(CLK_DIV);
    localparam logic signed [`TS_VOICE_W-1:0] SQ_HI = 16383;
    localparam logic signed [`TS_VOICE_W-1:0] SQ_LO = -16384;

    logic [DIV_W-1:0]              div_cnt;
    logic [`TS_PHASE_W-1:0]        phase      [`TS_NUM_CH];
    logic [`TS_PHASE_W-1:0]        next_phase [`TS_NUM_CH];
    logic signed [`TS_VOICE_W-1:0] shaped     [`TS_NUM_CH];

    function automatic logic signed [`TS_VOICE_W-1:0] shape(
        input logic [`TS_PHASE_W-1:0] ph,
        input wave_e                  wv,
        input logic [`TS_ATTEN_W-1:0] att
    );
        logic signed [`TS_VOICE_W-1:0] raw;
        if (wv == WAVE_SQUARE)
            raw = ph[`TS_PHASE_W-1] ? SQ_LO : SQ_HI;         // msb picks half
        else
            raw = signed'(ph[`TS_PHASE_W-1 -: `TS_VOICE_W]);  // top bits as saw
        return raw >>> att;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            div_cnt <= (div_cnt == DIV_W'(CLK_DIV - 1)) ? '0 : div_cnt + 1'b1;
            tick    <= div_cnt == DIV_W'(CLK_DIV - 1);       // one in CLK_DIV
        end
    end

    always_comb begin
        logic [`TS_PHASE_W-1:0] inc;
        for (int i = 0; i < `TS_NUM_CH; i++) begin
            inc           = `TS_PHASE_W'(regs.fnum[i]) << regs.block[i];
            next_phase[i] = phase[i] + inc;
            shaped[i]     = shape(next_phase[i], regs.wave[i], regs.atten[i]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `TS_NUM_CH; i++) begin
                phase[i]     <= '0;
                voice_out[i] <= '0;
            end
        end else if (tick) begin
            for (int i = 0; i < `TS_NUM_CH; i++) begin
                if (regs.kon[i]) begin
                    phase[i]     <= next_phase[i];
                    voice_out[i] <= shaped[i];   // wave of the new phase
                end else begin
                    phase[i]     <= '0;          // key-off parks at zero
                    voice_out[i] <= '0;
                end
            end
        end
    end

    a_tick_single: assert property (@(posedge clk) disable iff (!arst_n)
        tick |=> !tick);

endmodule

`default_nettype wire

// File: source/stereo_mixer.sv
/*
 * stereo_mixer
 * pan routing, left/right sums and sample pulse, plus key-on leds
 */
`timescale 1ns/1ns
`default_nettype none
`include "tone_synth_consts.svh"

module stereo_mixer (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          tick,
    input  wire signed [`TS_VOICE_W-1:0] voice_out [`TS_NUM_CH],
    voice_regs_if.mixer                  regs,
    output logic signed [`TS_MIX_W-1:0]  sample_l,
    output logic signed [`TS_MIX_W-1:0]  sample_r,
    output logic                         sample_clk_en,
    output logic [`TS_NUM_CH-1:0]        led
);
    logic                        tick_d;   // voice_out settled
    logic signed [`TS_MIX_W-1:0] sum_l;
    logic signed [`TS_MIX_W-1:0] sum_r;

    always_comb begin
        sum_l = '0;
        sum_r = '0;
        for (int i = 0; i < `TS_NUM_CH; i++) begin
            if (regs.pan_l[i])
                sum_l = sum_l + `TS_MIX_W'(voice_out[i]);  // sign extended
            if (regs.pan_r[i])
                sum_r = sum_r + `TS_MIX_W'(voice_out[i]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tick_d        <= 1'b0;
            sample_clk_en <= 1'b0;
            sample_l      <= '0;
            sample_r      <= '0;
            led           <= '0;
        end else begin
            tick_d        <= tick;
            sample_clk_en <= tick_d;      // marks new samples
            led           <= regs.kon;
            if (tick_d) begin
                sample_l <= sum_l;
                sample_r <= sum_r;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/tone_synth.sv
/*
 * tone_synth
 * four-channel tone generator top, host bus in and stereo samples out
 */
`timescale 1ns/1ns
`default_nettype none
`include "tone_synth_consts.svh"

module tone_synth (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          cs_n,
    input  wire                          rd_n,
    input  wire                          wr_n,
    input  wire [1:0]                    address,
    input  wire [`TS_DATA_W-1:0]         din,
    output logic [`TS_DATA_W-1:0]        dout,
    output logic                         sample_clk_en,
    output logic signed [`TS_MIX_W-1:0]  sample_l,
    output logic signed [`TS_MIX_W-1:0]  sample_r,
    output logic [`TS_NUM_CH-1:0]        led,
    output logic                         irq_n
);
    logic                          reg_wr;
    logic [`TS_DATA_W-1:0]         reg_index;
    logic [`TS_DATA_W-1:0]         reg_data;
    logic [`TS_DATA_W-1:0]         status;     // timer flags for readback
    logic [`TS_DATA_W-1:0]         t1_reload;
    logic [`TS_DATA_W-1:0]         t2_reload;
    logic                          t1_start;
    logic                          t2_start;
    logic                          t1_mask;
    logic                          t2_mask;
    logic                          flag_clr;
    logic                          tick;       // sample rate pulse
    logic signed [`TS_VOICE_W-1:0] voice_out [`TS_NUM_CH];

    voice_regs_if u_voice_regs ();

    host_port u_host_port (
        .clk, .arst_n, .cs_n, .rd_n, .wr_n, .address, .din,
        .status, .dout, .reg_wr, .reg_index, .reg_data
    );

    register_file u_register_file (
        .clk, .arst_n, .reg_wr, .reg_index, .reg_data,
        .regs(u_voice_regs.regs),
        .t1_reload, .t2_reload, .t1_start, .t2_start, .t1_mask, .t2_mask, .flag_clr
    );

    timers u_timers (
        .clk, .arst_n, .tick,
        .t1_reload, .t2_reload, .t1_start, .t2_start, .t1_mask, .t2_mask, .flag_clr,
        .status, .irq_n
    );

    voice_engine #(.CLK_DIV(`TS_CLK_DIV)) u_voice_engine (
        .clk, .arst_n, .regs(u_voice_regs.engine), .tick, .voice_out
    );

    stereo_mixer u_stereo_mixer (
        .clk, .arst_n, .tick, .voice_out, .regs(u_voice_regs.mixer),
        .sample_l, .sample_r, .sample_clk_en, .led
    );

endmodule

`default_nettype wire

// File: test/tb_tone_synth.sv
/*
 * tb_tone_synth
 * drives the host bus, keeps a phase model of the four voices
 * and checks samples, leds, status and irq_n against it
 */
`timescale 1ns/1ns
`default_nettype none
`include "tone_synth_consts.svh"

module tb_tone_synth;
    logic clk;
    logic arst_n;
    logic cs_n;
    logic rd_n;
    logic wr_n;
    logic [1:0] address;
    logic [`TS_DATA_W-1:0] din;
    logic [`TS_DATA_W-1:0] dout;
    logic sample_clk_en;
    logic signed [`TS_MIX_W-1:0] sample_l;
    logic signed [`TS_MIX_W-1:0] sample_r;
    logic [`TS_NUM_CH-1:0] led;
    logic irq_n;

    // model register copies and phase state
    logic [`TS_FNUM_W-1:0]  m_fnum  [`TS_NUM_CH];
    logic [`TS_BLOCK_W-1:0] m_block [`TS_NUM_CH];
    logic [`TS_ATTEN_W-1:0] m_atten [`TS_NUM_CH];
    logic [`TS_PHASE_W-1:0] m_phase [`TS_NUM_CH];
    logic [`TS_NUM_CH-1:0]  m_kon;
    logic [`TS_NUM_CH-1:0]  m_wave;               // 1 is square
    logic [`TS_NUM_CH-1:0]  m_pan_l;
    logic [`TS_NUM_CH-1:0]  m_pan_r;
    logic signed [`TS_MIX_W-1:0] exp_l;
    logic signed [`TS_MIX_W-1:0] exp_r;

    // settings to load per test
    logic [`TS_FNUM_W-1:0]  cfg_fnum  [`TS_NUM_CH];
    logic [`TS_BLOCK_W-1:0] cfg_block [`TS_NUM_CH];
    logic [`TS_ATTEN_W-1:0] cfg_atten [`TS_NUM_CH];
    logic [`TS_NUM_CH-1:0]  cfg_kon;
    logic [`TS_NUM_CH-1:0]  cfg_wave;
    logic [`TS_NUM_CH-1:0]  cfg_pan_l;
    logic [`TS_NUM_CH-1:0]  cfg_pan_r;

    logic [31:0] lcg_state;
    logic [7:0]  st;
    logic        irq_dropped;
    logic        seen_pulse;
    int          since_pulse;                    // clocks since last sample pulse
    string       cur_test;
    int          err_cnt;
    int          test_err_base;
    int          tests_run;
    int          tests_failed;

    tone_synth u_tone_synth (
        .clk, .arst_n, .cs_n, .rd_n, .wr_n, .address, .din,
        .dout, .sample_clk_en, .sample_l, .sample_r, .led, .irq_n
    );

    always #20 clk = !clk;                       // 40 ns period

    function automatic logic signed [`TS_VOICE_W-1:0] wave_sample(
        input logic [`TS_PHASE_W-1:0] ph,
        input logic                   sq,
        input logic [`TS_ATTEN_W-1:0] att
    );
        logic signed [`TS_VOICE_W-1:0] level;
        if (sq)
            level = ph[`TS_PHASE_W-1] ? -16'sd16384 : 16'sd16383;
        else
            level = $signed(ph[`TS_PHASE_W-1:`TS_PHASE_W-`TS_VOICE_W]);  // top 16 bits
        return level >>> att;
    endfunction

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // one phase step per observed sample pulse
    task automatic step_model();
        logic signed [`TS_MIX_W-1:0]   sum_l;
        logic signed [`TS_MIX_W-1:0]   sum_r;
        logic signed [`TS_VOICE_W-1:0] out;
        sum_l = '0;
        sum_r = '0;
        for (int i = 0; i < `TS_NUM_CH; i++) begin
            out = '0;
            if (m_kon[i]) begin
                m_phase[i] = m_phase[i] + (`TS_PHASE_W'(m_fnum[i]) << m_block[i]);
                out = wave_sample(m_phase[i], m_wave[i], m_atten[i]);
            end else begin
                m_phase[i] = '0;                  // key-off parks phase
            end
            if (m_pan_l[i])
                sum_l = sum_l + `TS_MIX_W'(out);
            if (m_pan_r[i])
                sum_r = sum_r + `TS_MIX_W'(out);
        end
        exp_l = sum_l;
        exp_r = sum_r;
    endtask

    always @(negedge clk)
        if (arst_n && sample_clk_en)
            step_model();                         // between the pulse edges

    // one pulse every TS_CLK_DIV clocks
    always @(negedge clk) begin
        if (arst_n) begin
            if (sample_clk_en) begin
                if (seen_pulse)
                    check_value("pulse spacing", `TS_CLK_DIV, since_pulse);
                seen_pulse  = 1'b1;
                since_pulse = 1;
            end else begin
                since_pulse = since_pulse + 1;
            end
        end
    end

    a_left: assert property (@(posedge clk) disable iff (!arst_n)
        sample_clk_en |-> sample_l == exp_l)
        else begin
            $display("mismatch %s sample_l: expected %0d actual %0d", cur_test, exp_l, sample_l);
            err_cnt++;
        end

    a_right: assert property (@(posedge clk) disable iff (!arst_n)
        sample_clk_en |-> sample_r == exp_r)
        else begin
            $display("mismatch %s sample_r: expected %0d actual %0d", cur_test, exp_r, sample_r);
            err_cnt++;
        end

    task automatic abort_run(input string reason);
        $display("error in %s: %s", cur_test, reason);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (expected == actual)
        else begin
            $display("mismatch %s %s: expected %0d actual %0d", cur_test, what, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test      = name;
        test_err_base = err_cnt;
    endtask

    task automatic finish_test();
        tests_run++;
        if (err_cnt > test_err_base) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", cur_test, err_cnt - test_err_base);
        end else begin
            $display("test %s: ok", cur_test);
        end
    endtask

    // mirrors the register map into the model copies
    task automatic update_model(input logic [7:0] idx, input logic [7:0] data);
        logic [1:0] ch;
        ch = idx[1:0];
        if ((idx & 8'hFC) == `TS_REG_FNUM_BASE) begin
            m_fnum[ch][7:0] = data;
        end else if ((idx & 8'hFC) == `TS_REG_KEY_BASE) begin
            m_kon[ch]       = data[5];
            m_block[ch]     = data[4:2];
            m_fnum[ch][9:8] = data[1:0];
        end else if ((idx & 8'hFC) == `TS_REG_VOICE_BASE) begin
            m_pan_r[ch] = data[5];
            m_pan_l[ch] = data[4];
            m_wave[ch]  = data[3];
            m_atten[ch] = data[2:0];
        end
    endtask

    // index cycle then data cycle, ends 2 ns after an edge
    task automatic host_write(input logic [7:0] idx, input logic [7:0] data);
        cs_n    = 1'b0;
        wr_n    = 1'b0;
        address = 2'd0;
        din     = idx;
        @(posedge clk);
        #2;
        address = 2'd1;
        din     = data;
        @(posedge clk);
        #2;
        cs_n = 1'b1;
        wr_n = 1'b1;
        din  = '0;
        update_model(idx, data);
    endtask

    task automatic host_read_status(output logic [7:0] value);
        cs_n    = 1'b0;
        rd_n    = 1'b0;
        address = 2'd0;
        #5;
        value = dout;                            // combinational readback
        @(posedge clk);
        #2;
        cs_n = 1'b1;
        rd_n = 1'b1;
    endtask

    task automatic wait_pulse();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #2;
            n++;
        end while (!sample_clk_en && n < 4 * `TS_CLK_DIV);
        if (!sample_clk_en)
            abort_run("no sample_clk_en pulse within the timeout");
    endtask

    task automatic run_pulses(input int count);
        repeat (count) wait_pulse();
    endtask

    task automatic wait_irq_level(input logic level, input int limit);
        int n;
        n = 0;
        while (irq_n !== level && n < limit) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (irq_n !== level)
            abort_run("irq_n did not reach the expected level in time");
    endtask

    // key off, load settings freely, then key on inside one sample window
    task automatic apply_config();
        wait_pulse();
        for (int i = 0; i < `TS_NUM_CH; i++)
            host_write(8'(`TS_REG_KEY_BASE + i), {3'b000, cfg_block[i], cfg_fnum[i][9:8]});
        wait_pulse();
        for (int i = 0; i < `TS_NUM_CH; i++) begin
            host_write(8'(`TS_REG_FNUM_BASE + i), cfg_fnum[i][7:0]);
            host_write(8'(`TS_REG_VOICE_BASE + i),
                       {2'b00, cfg_pan_r[i], cfg_pan_l[i], cfg_wave[i], cfg_atten[i]});
        end
        wait_pulse();
        for (int i = 0; i < `TS_NUM_CH; i++)
            host_write(8'(`TS_REG_KEY_BASE + i),
                       {2'b00, cfg_kon[i], cfg_block[i], cfg_fnum[i][9:8]});
    endtask

    task automatic set_channel(input int ch, input logic [9:0] fnum, input logic [2:0] block,
                               input logic sq, input logic [2:0] att, input logic pl,
                               input logic pr, input logic kon);
        cfg_fnum[ch]  = fnum;
        cfg_block[ch] = block;
        cfg_wave[ch]  = sq;
        cfg_atten[ch] = att;
        cfg_pan_l[ch] = pl;
        cfg_pan_r[ch] = pr;
        cfg_kon[ch]   = kon;
    endtask

    initial begin
        logic [31:0] r;
        clk = 1'b0;
        arst_n = 1'b0;
        cs_n = 1'b1;
        rd_n = 1'b1;
        wr_n = 1'b1;
        address = 2'd0;
        din = '0;
        lcg_state = 32'h9bec_902b;
        err_cnt = 0;
        tests_run = 0;
        tests_failed = 0;
        seen_pulse = 1'b0;
        since_pulse = 0;
        exp_l = '0;
        exp_r = '0;
        for (int i = 0; i < `TS_NUM_CH; i++) begin
            set_channel(i, 10'd0, 3'd0, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0);
            update_model(8'(`TS_REG_KEY_BASE + i), 8'h00);
            update_model(8'(`TS_REG_VOICE_BASE + i), 8'h00);
            update_model(8'(`TS_REG_FNUM_BASE + i), 8'h00);
            m_phase[i] = '0;
        end
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;

        start_test("reset_state");
        check_value("irq_n", 1, irq_n);
        check_value("sample_l", 0, sample_l);
        check_value("sample_r", 0, sample_r);
        check_value("led", 0, led);
        host_read_status(st);
        check_value("status", 0, st);
        finish_test();

        start_test("saw_tone");
        set_channel(0, 10'h155, 3'd7, 1'b0, 3'd0, 1'b1, 1'b0, 1'b1);  // wraps into negative half
        apply_config();
        run_pulses(20);
        check_value("sample_r", 0, sample_r);
        check_value("led[0]", 1, led[0]);
        finish_test();

        start_test("square_atten_pan");
        set_channel(0, 10'h155, 3'd3, 1'b0, 3'd0, 1'b1, 1'b0, 1'b0);
        set_channel(1, 10'h2a0, 3'd6, 1'b1, 3'd2, 1'b0, 1'b1, 1'b1);  // both square halves
        set_channel(2, 10'h0f3, 3'd4, 1'b0, 3'd1, 1'b1, 1'b1, 1'b1);
        apply_config();
        run_pulses(20);
        finish_test();

        start_test("key_off");
        wait_pulse();
        for (int i = 0; i < `TS_NUM_CH; i++)
            host_write(8'(`TS_REG_KEY_BASE + i), 8'h00);
        wait_pulse();
        check_value("sample_l", 0, sample_l);
        check_value("sample_r", 0, sample_r);
        check_value("led", 0, led);
        run_pulses(4);
        finish_test();

        start_test("timers");
        host_write(`TS_REG_T1, 8'hfc);
        host_write(`TS_REG_TCTL, 8'h01);         // timer 1 on, unmasked
        wait_irq_level(1'b0, 20 * `TS_CLK_DIV);
        host_read_status(st);
        check_value("status t1", 8'hc0, st);
        host_write(`TS_REG_TCTL, 8'h80);         // flag reset, timers stopped
        wait_irq_level(1'b1, 8);
        host_read_status(st);
        check_value("status cleared", 0, st);
        host_write(`TS_REG_T2, 8'hfe);
        host_write(`TS_REG_TCTL, 8'h22);         // timer 2 on, masked
        irq_dropped = 1'b0;
        st = '0;
        for (int n = 0; n < 40 * `TS_CLK_DIV && !st[5]; n++) begin
            host_read_status(st);
            if (!irq_n)
                irq_dropped = 1'b1;
        end
        if (!st[5])
            abort_run("timer 2 flag never set");
        check_value("status t2", 8'h20, st);
        check_value("irq_n dropped while masked", 0, irq_dropped);
        host_write(`TS_REG_TCTL, 8'h80);
        finish_test();

        start_test("random_settings");
        for (int round = 0; round < 8; round++) begin
            for (int i = 0; i < `TS_NUM_CH; i++) begin
                r = lcg_next();
                set_channel(i, r[31:22], r[21:19], r[18], r[17:15], r[14], r[13], 1'b1);
            end
            apply_config();
            run_pulses(8);
        end
        finish_test();

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, err_cnt);
        if (err_cnt == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tone_synth.f
+incdir+include
source/tone_synth_pkg.sv
source/voice_regs_if.sv
source/host_port.sv
source/register_file.sv
source/timers.sv
source/voice_engine.sv
source/stereo_mixer.sv
source/tone_synth.sv
test/tb_tone_synth.sv

// File: run_sim.sh
#!/bin/sh
# build the tone_synth testbench with Verilator, run it, then judge by the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_tone_synth \
    -f tone_synth.f -o tb_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -qx "STATUS: PASS" sim.log && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }
